/* cpuGolden.txt */
# T index randomAck | P address word | E address data (expected store) | S halted illegalOp
# Register ALU ops
T 0 0
P 0000 308000F0
P 0001 31000123
P 0002 31800024
P 0003 02090000
P 0004 52000100
P 0005 0A090000
P 0006 52000101
P 0007 12090000
P 0008 52000102
P 0009 1A090000
P 000A 52000103
P 000B 22118000
P 000C 52000104
P 000D 2A098000
P 000E 52000105
P 000F 58000000
E 0100 00000213
E 0101 FFFFFFCD
E 0102 00000020
E 0103 000001F3
E 0104 00001230
E 0105 0000000F
S 1 0
# Immediates with sign extension
T 1 0
P 0000 3087FFFD
P 0001 50800200
P 0002 3107FFFF
P 0003 39940F0F
P 0004 51800201
P 0005 42050001
P 0006 52000202
P 0007 30000005
P 0008 50000203
P 0009 58000000
E 0200 FFFFFFFD
E 0201 FFFC0F0F
E 0202 FFFD0001
E 0203 00000000
S 1 0
# Load and store round trip
T 2 0
P 0000 30800300
P 0001 3101ABCD
P 0002 51080005
P 0003 49880005
P 0004 518FFFFE
P 0005 4A080010
P 0006 52080011
P 0007 58000000
P 0310 CAFEF00D
E 0305 0001ABCD
E 02FE 0001ABCD
E 0311 CAFEF00D
S 1 0
# Same program with random ack delay
T 3 1
P 0000 30800300
P 0001 3101ABCD
P 0002 51080005
P 0003 49880005
P 0004 518FFFFE
P 0005 4A080010
P 0006 52080011
P 0007 58000000
P 0310 CAFEF00D
E 0305 0001ABCD
E 02FE 0001ABCD
E 0311 CAFEF00D
S 1 0
# Halt stops execution
T 4 1
P 0000 30800007
P 0001 50800040
P 0002 58000000
P 0003 50800041
E 0040 00000007
S 1 0
# Illegal opcode
T 5 0
P 0000 30800009
P 0001 50800050
P 0002 F8000000
P 0003 50800051
E 0050 00000009
S 1 1

/* flist.f */
cpuPkg.sv
regFile.sv
aluUnit.sv
busDatapath.sv
controlSequencer.sv
cpuTop.sv
cpuBus_chk.sv
cpuTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module cpuTb -o cpuSim

out=$(./obj_dir/cpuSim || true)
echo "$out"

if echo "$out" | grep -q "RESULT: PASS"; then
   exit 0
else
   exit 1
fi

/* cpuTb.sv */
// CPU core testbench
`timescale 1ns/1ns

module cpuTb import cpuPkg::*;;

   logic                 Clock;
   logic                 rstN;
   logic                 wbCyc;
   logic                 wbStb;
   logic                 wbWe;
   logic [addrWidth-1:0] wbAdr;
   logic [dataWidth-1:0] wbDatOut;
   logic [dataWidth-1:0] wbDatIn;
   logic                 wbAck;
   logic                 halted;
   logic                 illegalOp;

   logic [dataWidth-1:0] mem [0:2**addrWidth-1];
   int   progTest[$];
   logic [addrWidth-1:0] progAddr[$];
   logic [dataWidth-1:0] progWord[$];
   int   expTest[$];
   logic [addrWidth-1:0] expAddr[$];
   logic [dataWidth-1:0] expData[$];
   int   randAck[$];
   logic statHalt[$];
   logic statIll[$];
   logic [addrWidth-1:0] curAddr[$];
   logic [dataWidth-1:0] curData[$];
   int   curRand;
   int   errors;
   int   seed;
   int   limitCycles;

   cpuTop uut (
      .Clock     (Clock),
      .rstN      (rstN),
      .wbCyc     (wbCyc),
      .wbStb     (wbStb),
      .wbWe      (wbWe),
      .wbAdr     (wbAdr),
      .wbDatOut  (wbDatOut),
      .wbDatIn   (wbDatIn),
      .wbAck     (wbAck),
      .halted    (halted),
      .illegalOp (illegalOp)
   );

   initial begin
      Clock = 1'b0;
      forever #50 Clock = ~Clock;
   end

   task automatic checkValue(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
      if (got !== exp) begin
         $display("ERR %s got %h expected %h", name, got, exp);
         errors++;
      end
   endtask

   // Reads test blocks, program words, expected stores and status
   task automatic readGolden();
      int fd;
      int n;
      int testIdx;
      string line;
      logic [7:0] tag;
      logic [31:0] v1;
      logic [31:0] v2;
      testIdx = -1;
      fd = $fopen("cpuGolden.txt", "r");
      if (fd == 0) begin
         $display("Could not open the golden file cpuGolden.txt");
         errors++;
         return;
      end
      while ($fgets(line, fd) > 0) begin
         if (line.len() < 2 || line[0] == "#") begin
            continue;
         end
         n = $sscanf(line, "%c %h %h", tag, v1, v2);
         if (n != 3) begin
            $display("Malformed line in golden file: %s", line);
            errors++;
            continue;
         end
         case (tag)
            "T": begin
               testIdx++;
               randAck.push_back(int'(v2));
            end
            "P": begin
               progTest.push_back(testIdx);
               progAddr.push_back(v1[addrWidth-1:0]);
               progWord.push_back(v2);
            end
            "E": begin
               expTest.push_back(testIdx);
               expAddr.push_back(v1[addrWidth-1:0]);
               expData.push_back(v2);
            end
            "S": begin
               statHalt.push_back(v1[0]);
               statIll.push_back(v2[0]);
            end
            default: begin
               $display("Unknown line in golden file: %s", line);
               errors++;
            end
         endcase
      end
      $fclose(fd);
   endtask

   // Memory model with 0 to 3 cycles of ack delay when enabled
   initial begin
      int waitCnt;
      logic armed;
      waitCnt = 0;
      armed   = 1'b0;
      forever begin
         @(posedge Clock);
         #10;
         // The core must release the strobe in the cycle after an ack
         if (rstN && wbAck && wbStb) begin
            $display("Strobe still high in the cycle after an ack, address %h", wbAdr);
            errors++;
         end
         wbAck = 1'b0;
         if (!rstN) begin
            armed = 1'b0;
         end
         else if (wbCyc && wbStb) begin
            if (!armed) begin
               waitCnt = curRand ? (unsigned'($random(seed)) % 4) : 0;
               armed   = 1'b1;
            end
            if (waitCnt == 0) begin
               if (wbWe) begin
                  mem[wbAdr] = wbDatOut;
                  if (curAddr.size() == 0) begin
                     $display("Store to address %h arrived with no store expected", wbAdr);
                     errors++;
                  end
                  else begin
                     checkValue("wbAdr", 32'(wbAdr), 32'(curAddr.pop_front()));
                     checkValue("wbDatOut", wbDatOut, curData.pop_front());
                  end
               end
               else begin
                  wbDatIn = mem[wbAdr];
               end
               wbAck = 1'b1;
               armed = 1'b0;
            end
            else begin
               waitCnt--;
            end
         end
      end
   end

   task automatic runTest(input int t);
      for (int a = 0; a < 2**addrWidth; a++) begin
         // Unused words decode as an illegal opcode
         mem[a] = 32'hF800_0000 | a;
      end
      curAddr.delete();
      curData.delete();
      foreach (progTest[i]) begin
         if (progTest[i] == t) begin
            mem[progAddr[i]] = progWord[i];
         end
      end
      foreach (expTest[i]) begin
         if (expTest[i] == t) begin
            curAddr.push_back(expAddr[i]);
            curData.push_back(expData[i]);
         end
      end
      curRand = randAck[t];
      rstN = 1'b0;
      repeat (2) @(posedge Clock);
      #10;
      rstN = 1'b1;
      @(posedge Clock);
      #10;
      checkValue("halted", 32'(halted), 32'h0);
      checkValue("illegalOp", 32'(illegalOp), 32'h0);
      checkValue("wbCyc", 32'(wbCyc), 32'h1);
      checkValue("wbStb", 32'(wbStb), 32'h1);
      checkValue("wbAdr", 32'(wbAdr), 32'h0);
      while (!halted) begin
         @(posedge Clock);
         #10;
      end
      repeat (5) begin
         @(posedge Clock);
         #10;
         if (wbStb || wbCyc) begin
            $display("Test %0d: bus cycle seen after halt", t);
            errors++;
         end
      end
      checkValue("halted", 32'(halted), 32'(statHalt[t]));
      checkValue("illegalOp", 32'(illegalOp), 32'(statIll[t]));
      if (curAddr.size() != 0) begin
         $display("Test %0d: halted with %0d stores still missing", t, curAddr.size());
         errors++;
      end
   endtask

   // Watchdog sized from the program lengths
   initial begin
      wait (limitCycles > 0);
      repeat (limitCycles) @(posedge Clock);
      $display("Timeout: the tests did not finish within %0d cycles", limitCycles);
      $display("RESULT: FAIL");
      $finish;
   end

   initial begin
      rstN    = 1'b0;
      wbAck   = 1'b0;
      wbDatIn = '0;
      errors  = 0;
      seed    = 85;
      curRand = 0;
      limitCycles = 0;
      readGolden();
      limitCycles = progWord.size() * 40 + statHalt.size() * 200 + 1;
      for (int t = 0; t < statHalt.size(); t++) begin
         runTest(t);
      end
      $display("Errors: %0d", errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end
      else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* cpuBus_chk.sv */
// Wishbone port checks
`timescale 1ns/1ns

module cpuBusChk import cpuPkg::*; (
   input logic                 Clock,
   input logic                 rstN,
   input logic                 wbCyc,
   input logic                 wbStb,
   input logic                 wbWe,
   input logic [addrWidth-1:0] wbAdr,
   input logic [dataWidth-1:0] wbDatOut,
   input logic                 wbAck,
   input logic                 halted
);

   stbNeedsCyc: assert property (@(posedge Clock) disable iff (!rstN) wbStb |-> wbCyc)
      else $error("wbStb high without wbCyc");

   // Request held steady until the ack edge
   stableWait: assert property (@(posedge Clock) disable iff (!rstN)
      (wbStb && !wbAck) |=> ($stable(wbAdr) && $stable(wbWe) && $stable(wbDatOut)))
      else $error("Wishbone request changed while waiting for ack");

   haltHolds: assert property (@(posedge Clock) disable iff (!rstN) halted |=> halted)
      else $error("halted fell without reset");

   quietInReset: assert property (@(posedge Clock) !rstN |-> !wbStb)
      else $error("Strobe during reset");

endmodule

bind cpuTop cpuBusChk busChk (
   .Clock    (Clock),
   .rstN     (rstN),
   .wbCyc    (wbCyc),
   .wbStb    (wbStb),
   .wbWe     (wbWe),
   .wbAdr    (wbAdr),
   .wbDatOut (wbDatOut),
   .wbAck    (wbAck),
   .halted   (halted)
);

/* cpuTop.sv */
// CPU core top level
`timescale 1ns/1ns

module cpuTop import cpuPkg::*; (
   input  logic                 Clock,
   input  logic                 rstN,
   output logic                 wbCyc,
   output logic                 wbStb,
   output logic                 wbWe,
   output logic [addrWidth-1:0] wbAdr,
   output logic [dataWidth-1:0] wbDatOut,
   input  logic [dataWidth-1:0] wbDatIn,
   input  logic                 wbAck,
   output logic                 halted,
   output logic                 illegalOp
);

   logic pcOut, mdrOut, rzOut, regOut, immOut;
   logic pcIn, irIn, ryIn, rzIn, marIn, mdrIn, regIn;
   logic incPc, memLoad, fetchPhase;
   logic [regIdxWidth-1:0] regSel;
   logic [dataWidth-1:0] irWord;
   aluOpT aluOp;

   controlSequencer seq (
      .Clock (Clock), .rstN (rstN), .irWord (irWord), .wbAck (wbAck),
      .wbCyc (wbCyc), .wbStb (wbStb), .wbWe (wbWe),
      .pcOut (pcOut), .mdrOut (mdrOut), .rzOut (rzOut), .regOut (regOut), .immOut (immOut),
      .pcIn (pcIn), .irIn (irIn), .ryIn (ryIn), .rzIn (rzIn),
      .marIn (marIn), .mdrIn (mdrIn), .regIn (regIn),
      .incPc (incPc), .regSel (regSel), .aluOp (aluOp), .memLoad (memLoad),
      .fetchPhase (fetchPhase), .halted (halted), .illegalOp (illegalOp)
   );

   busDatapath dp (
      .Clock (Clock), .rstN (rstN),
      .pcOut (pcOut), .mdrOut (mdrOut), .rzOut (rzOut), .regOut (regOut), .immOut (immOut),
      .pcIn (pcIn), .irIn (irIn), .ryIn (ryIn), .rzIn (rzIn),
      .marIn (marIn), .mdrIn (mdrIn), .regIn (regIn),
      .incPc (incPc), .regSel (regSel), .aluOp (aluOp),
      .memData (wbDatIn), .memLoad (memLoad), .fetchPhase (fetchPhase),
      .irWord (irWord), .memAdr (wbAdr), .memDataOut (wbDatOut)
   );

endmodule

/* controlSequencer.sv */
// Instruction step sequencer
`timescale 1ns/1ns

module controlSequencer import cpuPkg::*; (
   input  logic                   Clock,
   input  logic                   rstN,
   input  logic [dataWidth-1:0]   irWord,
   input  logic                   wbAck,
   output logic                   wbCyc,
   output logic                   wbStb,
   output logic                   wbWe,
   output logic                   pcOut,
   output logic                   mdrOut,
   output logic                   rzOut,
   output logic                   regOut,
   output logic                   immOut,
   output logic                   pcIn,
   output logic                   irIn,
   output logic                   ryIn,
   output logic                   rzIn,
   output logic                   marIn,
   output logic                   mdrIn,
   output logic                   regIn,
   output logic                   incPc,
   output logic [regIdxWidth-1:0] regSel,
   output aluOpT                  aluOp,
   output logic                   memLoad,
   output logic                   fetchPhase,
   output logic                   halted,
   output logic                   illegalOp
);

   stepT step;
   stepT stepNext;
   opcodeT opcode;
   logic [regIdxWidth-1:0] ra;
   logic [regIdxWidth-1:0] rb;
   logic [regIdxWidth-1:0] rc;
   logic reqActive;
   logic ackIn;
   logic isLegal;
   logic isHalt;
   logic isImm;
   logic isLoad;
   logic isStore;

   assign opcode = opcodeT'(irWord[opcodeMsb:opcodeLsb]);
   assign ra     = irWord[raMsb:raLsb];
   assign rb     = irWord[rbMsb:rbLsb];
   assign rc     = irWord[rcMsb:rcLsb];

   // Acks outside a request are ignored
   assign ackIn = wbAck & reqActive;

   always_comb begin
      isLegal = 1'b1;
      isHalt  = 1'b0;
      isImm   = 1'b0;
      isLoad  = 1'b0;
      isStore = 1'b0;
      aluOp   = aluAdd;
      case (opcode)
         opAdd:  aluOp = aluAdd;
         opSub:  aluOp = aluSub;
         opAnd:  aluOp = aluAnd;
         opOr:   aluOp = aluOr;
         opShl:  aluOp = aluShl;
         opShr:  aluOp = aluShr;
         opAddi: isImm = 1'b1;
         opAndi: begin
            aluOp = aluAnd;
            isImm = 1'b1;
         end
         opOri: begin
            aluOp = aluOr;
            isImm = 1'b1;
         end
         // Address is base plus immediate
         opLd: begin
            isImm  = 1'b1;
            isLoad = 1'b1;
         end
         opSt: begin
            isImm   = 1'b1;
            isStore = 1'b1;
         end
         opHalt:  isHalt = 1'b1;
         default: isLegal = 1'b0;
      endcase
   end

   always_comb begin
      stepNext = step;
      case (step)
         stepFetch:   if (ackIn) stepNext = stepDecode;
         stepDecode:  stepNext = (isLegal && !isHalt) ? stepOperand : stepHalted;
         stepOperand: stepNext = (isLoad || isStore) ? stepExecute : stepWrite;
         stepExecute: stepNext = stepMem;
         stepWrite:   stepNext = stepFetch;
         stepMem:     if (ackIn) stepNext = stepFetch;
         default:     stepNext = stepHalted;
      endcase
   end

   // Request is registered so it drops the cycle after the ack edge
   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         step      <= stepFetch;
         reqActive <= 1'b0;
         wbWe      <= 1'b0;
         illegalOp <= 1'b0;
      end
      else begin
         step      <= stepNext;
         reqActive <= ((stepNext == stepFetch) || (stepNext == stepMem)) && !ackIn;
         wbWe      <= (stepNext == stepMem) && isStore;
         if ((step == stepDecode) && !isLegal) begin
            illegalOp <= 1'b1;
         end
      end
   end

   always_comb begin
      rzOut   = 1'b0;
      regOut  = 1'b0;
      immOut  = 1'b0;
      irIn    = 1'b0;
      ryIn    = 1'b0;
      rzIn    = 1'b0;
      marIn   = 1'b0;
      mdrIn   = 1'b0;
      regIn   = 1'b0;
      incPc   = 1'b0;
      memLoad = 1'b0;
      regSel  = ra;
      case (step)
         stepFetch: begin
            irIn    = ackIn;
            incPc   = ackIn;
            memLoad = ackIn;
         end
         stepDecode: begin
            // Base or first operand into RY
            regSel = rb;
            regOut = isLegal && !isHalt;
            ryIn   = isLegal && !isHalt;
         end
         stepOperand: begin
            rzIn   = 1'b1;
            immOut = isImm;
            regOut = !isImm;
            regSel = rc;
         end
         stepExecute: begin
            marIn  = 1'b1;
            regOut = isStore;
            mdrIn  = isStore;
         end
         stepWrite: begin
            rzOut = 1'b1;
            regIn = 1'b1;
         end
         stepMem: begin
            memLoad = isLoad && ackIn;
            regIn   = isLoad && ackIn;
         end
         default: begin
            regSel = ra;
         end
      endcase
   end

   // No branches, so PC and MDR never drive the bus and PC never loads
   assign pcOut  = 1'b0;
   assign mdrOut = 1'b0;
   assign pcIn   = 1'b0;

   assign wbCyc      = reqActive;
   assign wbStb      = reqActive;
   assign fetchPhase = (step == stepFetch);
   assign halted     = (step == stepHalted);

endmodule

/* busDatapath.sv */
// Single bus datapath
`timescale 1ns/1ns

module busDatapath import cpuPkg::*; (
   input  logic                   Clock,
   input  logic                   rstN,
   input  logic                   pcOut,
   input  logic                   mdrOut,
   input  logic                   rzOut,
   input  logic                   regOut,
   input  logic                   immOut,
   input  logic                   pcIn,
   input  logic                   irIn,
   input  logic                   ryIn,
   input  logic                   rzIn,
   input  logic                   marIn,
   input  logic                   mdrIn,
   input  logic                   regIn,
   input  logic                   incPc,
   input  logic [regIdxWidth-1:0] regSel,
   input  aluOpT                  aluOp,
   input  logic [dataWidth-1:0]   memData,
   input  logic                   memLoad,
   input  logic                   fetchPhase,
   output logic [dataWidth-1:0]   irWord,
   output logic [addrWidth-1:0]   memAdr,
   output logic [dataWidth-1:0]   memDataOut
);

   logic [addrWidth-1:0] pc;
   logic [addrWidth-1:0] mar;
   logic [dataWidth-1:0] ir;
   logic [dataWidth-1:0] ry;
   logic [dataWidth-1:0] rz;
   logic [dataWidth-1:0] mdr;
   logic [dataWidth-1:0] busVal;
   logic [dataWidth-1:0] immExt;
   logic [dataWidth-1:0] regData;
   logic [dataWidth-1:0] aluResult;
   logic [dataWidth-1:0] loadData;

   // Sign extend the 19-bit immediate field
   assign immExt = {{(dataWidth - immMsb - 1){ir[immMsb]}}, ir[immMsb:0]};

   // One-hot sources, bus reads zero when idle
   assign busVal = ({dataWidth{pcOut}}  & {{(dataWidth - addrWidth){1'b0}}, pc})
                 | ({dataWidth{mdrOut}} & mdr)
                 | ({dataWidth{rzOut}}  & rz)
                 | ({dataWidth{regOut}} & regData)
                 | ({dataWidth{immOut}} & immExt);

   // Memory word replaces the bus at fetch and load acks
   assign loadData = memLoad ? memData : busVal;

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         pc <= '0;
      end
      else if (pcIn) begin
         pc <= busVal[addrWidth-1:0];
      end
      else if (incPc) begin
         pc <= pc + 1'b1;
      end
   end

   always_ff @(posedge Clock) begin
      if (irIn) begin
         ir <= loadData;
      end
      if (ryIn) begin
         ry <= busVal;
      end
      if (rzIn) begin
         rz <= aluResult;
      end
      // MAR takes RZ directly so the bus is free for the store data
      if (marIn) begin
         mar <= rz[addrWidth-1:0];
      end
      if (mdrIn) begin
         mdr <= busVal;
      end
   end

   regFile regs (
      .Clock     (Clock),
      .rstN      (rstN),
      .regSel    (regSel),
      .writeEn   (regIn),
      .writeData (loadData),
      .readData  (regData)
   );

   // RY is operand A, the bus is operand B
   aluUnit alu (
      .aluOp  (aluOp),
      .opA    (ry),
      .opB    (busVal),
      .result (aluResult)
   );

   assign irWord     = ir;
   assign memAdr     = fetchPhase ? pc : mar;
   assign memDataOut = mdr;

endmodule

/* aluUnit.sv */
// Arithmetic and logic unit
`timescale 1ns/1ns

module aluUnit import cpuPkg::*; (
   input  aluOpT                aluOp,
   input  logic [dataWidth-1:0] opA,
   input  logic [dataWidth-1:0] opB,
   output logic [dataWidth-1:0] result
);

   logic [4:0] shiftAmt;

   // Only the low five bits count for shifts
   assign shiftAmt = opB[4:0];

   always_comb begin
      case (aluOp)
         aluAdd: begin
            result = opA + opB;
         end
         aluSub: begin
            // Wraps modulo 2^32
            result = opA - opB;
         end
         aluAnd: begin
            result = opA & opB;
         end
         aluOr: begin
            result = opA | opB;
         end
         aluShl: begin
            result = opA << shiftAmt;
         end
         aluShr: begin
            // Logical, zeros shifted in
            result = opA >> shiftAmt;
         end
         default: begin
            result = '0;
         end
      endcase
   end

endmodule

/* regFile.sv */
// General register file
`timescale 1ns/1ns

module regFile import cpuPkg::*; (
   input  logic                   Clock,
   input  logic                   rstN,
   input  logic [regIdxWidth-1:0] regSel,
   input  logic                   writeEn,
   input  logic [dataWidth-1:0]   writeData,
   output logic [dataWidth-1:0]   readData
);

   logic [dataWidth-1:0] regs [2**regIdxWidth];

   // Register 0 keeps its reset value, writes are dropped
   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < 2**regIdxWidth; i++) begin
            regs[i] <= '0;
         end
      end
      else if (writeEn && (regSel != '0)) begin
         regs[regSel] <= writeData;
      end
   end

   // Combinational read, same index as the write port
   always_comb begin
      if (regSel == '0) begin
         readData = '0;
      end
      else begin
         readData = regs[regSel];
      end
   end

endmodule

/* cpuPkg.sv */
// CPU shared definitions
package cpuPkg;

   localparam int dataWidth   = 32;
   localparam int addrWidth   = 16;
   localparam int regIdxWidth = 4;

   // Instruction field positions
   localparam int opcodeMsb = 31;
   localparam int opcodeLsb = 27;
   localparam int raMsb     = 26;
   localparam int raLsb     = 23;
   localparam int rbMsb     = 22;
   localparam int rbLsb     = 19;
   localparam int rcMsb     = 18;
   localparam int rcLsb     = 15;
   localparam int immMsb    = 18;

   // Codes above opHalt are illegal
   typedef enum logic [4:0] {
      opAdd  = 5'd0,
      opSub  = 5'd1,
      opAnd  = 5'd2,
      opOr   = 5'd3,
      opShl  = 5'd4,
      opShr  = 5'd5,
      opAddi = 5'd6,
      opAndi = 5'd7,
      opOri  = 5'd8,
      opLd   = 5'd9,
      opSt   = 5'd10,
      opHalt = 5'd11
   } opcodeT;

   typedef enum logic [2:0] {
      stepFetch,
      stepDecode,
      stepOperand,
      stepExecute,
      stepWrite,
      stepMem,
      stepHalted
   } stepT;

   typedef enum logic [2:0] {
      aluAdd,
      aluSub,
      aluAnd,
      aluOr,
      aluShl,
      aluShr
   } aluOpT;

endpackage
